// ==== design/gf_pkg.sv ====
package gf_pkg;

	////////////////////////////////////////////////////////////
	// widths
	////////////////////////////////////////////////////////////

	localparam int GF_WIDTH = 32;
	localparam int NIB_WIDTH = 4;
	localparam int NIB_BEATS = GF_WIDTH / NIB_WIDTH;

	typedef logic [GF_WIDTH-1:0] gf_word_t;

	////////////////////////////////////////////////////////////
	// opcodes and bundles
	////////////////////////////////////////////////////////////

	typedef enum logic [1:0] {
		OP_ADD = 2'd0,
		OP_SUB = 2'd1,
		OP_MUL = 2'd2,
		OP_DIV = 2'd3
	} gf_op_e;

	// one full operation as assembled from the nibble ports
	typedef struct packed {
		gf_op_e   op;
		gf_word_t a;
		gf_word_t b;
		gf_word_t p;
	} gf_operands_t;

	// valid is a single-cycle strobe
	typedef struct packed {
		gf_word_t value;
		logic     valid;
	} gf_result_t;

endpackage

// ==== design/gf_operand_loader.sv ====
`timescale 1ns/10ps

module gf_operand_loader (
	input  logic                         i_clk,
	input  logic                         i_rst,
	input  logic                         i_start,
	input  logic [gf_pkg::NIB_WIDTH-1:0] i_nib_a,
	input  logic [gf_pkg::NIB_WIDTH-1:0] i_nib_b,
	input  logic [gf_pkg::NIB_WIDTH-1:0] i_nib_p,
	input  gf_pkg::gf_op_e               i_op,
	input  logic                         i_done,
	output gf_pkg::gf_operands_t         o_operands,
	output logic                         o_go,
	output logic                         o_busy
);
	import gf_pkg::*;

	localparam int CNT_W = $clog2(NIB_BEATS);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_LOAD,
		ST_LAUNCH,
		ST_WAIT
	} state_e;

	state_e           state;
	state_e           state_n;
	logic [CNT_W-1:0] beat;
	logic             capture;
	gf_operands_t     opnd;

	// beat 0 comes together with the start pulse
	assign capture = (state == ST_IDLE && i_start) || (state == ST_LOAD);

	always_comb begin
		state_n = state;
		case (state)
			ST_IDLE: begin
				if (i_start) begin
					state_n = ST_LOAD;
				end
			end
			ST_LOAD: begin
				if (beat == CNT_W'(NIB_BEATS - 1)) begin
					state_n = ST_LAUNCH;
				end
			end
			ST_LAUNCH: begin
				state_n = ST_WAIT;
			end
			default: begin
				// hold until the last nibble has left
				if (i_done) begin
					state_n = ST_IDLE;
				end
			end
		endcase
	end

	always_ff @(posedge i_clk or posedge i_rst) begin
		if (i_rst) begin
			state <= ST_IDLE;
			beat <= '0;
		end else begin
			state <= state_n;
			// wraps back to 0 after the last beat
			if (capture) begin
				beat <= beat + 1'b1;
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (capture) begin
			opnd.a[beat*NIB_WIDTH +: NIB_WIDTH] <= i_nib_a;
			opnd.b[beat*NIB_WIDTH +: NIB_WIDTH] <= i_nib_b;
			opnd.p[beat*NIB_WIDTH +: NIB_WIDTH] <= i_nib_p;
		end
		if (state == ST_IDLE && i_start) begin
			opnd.op <= i_op;
		end
	end

	assign o_operands = opnd;
	assign o_go = (state == ST_LAUNCH);
	assign o_busy = (state != ST_IDLE);

endmodule

// ==== design/gf_add_sub_unit.sv ====
`timescale 1ns/10ps

module gf_add_sub_unit (
	input  logic                 i_clk,
	input  logic                 i_rst,
	input  logic                 i_go,
	input  gf_pkg::gf_operands_t i_operands,
	output gf_pkg::gf_result_t   o_result
);
	import gf_pkg::*;

	logic [GF_WIDTH:0] sum;
	logic [GF_WIDTH:0] sum_red;
	gf_word_t          add_res;
	gf_word_t          diff;
	gf_word_t          sub_res;
	logic              take;
	gf_word_t          value_q;
	logic              valid_q;

	////////////////////////////////////////////////////////////
	// addition
	////////////////////////////////////////////////////////////

	// carry kept so a wrapped sum still compares correctly
	assign sum = {1'b0, i_operands.a} + {1'b0, i_operands.b};
	assign sum_red = sum - {1'b0, i_operands.p};
	assign add_res = (sum >= {1'b0, i_operands.p}) ? sum_red[GF_WIDTH-1:0]
		: sum[GF_WIDTH-1:0];

	////////////////////////////////////////////////////////////
	// subtraction
	////////////////////////////////////////////////////////////

	// borrow is repaired by adding p back, modulo 2^32
	assign diff = i_operands.a - i_operands.b;
	assign sub_res = (i_operands.a < i_operands.b) ? diff + i_operands.p : diff;

	assign take = i_go && (i_operands.op == OP_ADD || i_operands.op == OP_SUB);

	always_ff @(posedge i_clk or posedge i_rst) begin
		if (i_rst) begin
			valid_q <= 1'b0;
		end else begin
			valid_q <= take;
		end
	end

	always_ff @(posedge i_clk) begin
		if (take) begin
			value_q <= (i_operands.op == OP_SUB) ? sub_res : add_res;
		end
	end

	assign o_result = '{value: value_q, valid: valid_q};

endmodule

// ==== design/gf_mul_div_unit.sv ====
`timescale 1ns/10ps

module gf_mul_div_unit (
	input  logic                 i_clk,
	input  logic                 i_rst,
	input  logic                 i_go,
	input  gf_pkg::gf_operands_t i_operands,
	output gf_pkg::gf_result_t   o_result
);
	import gf_pkg::*;

	// the inversion loop runs at most 2*GF_WIDTH steps
	localparam int CNT_W = $clog2(2 * GF_WIDTH + 1);
	localparam int IDX_W = $clog2(GF_WIDTH);

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_MUL,
		ST_MFIX,
		ST_DLOOP,
		ST_DHALF
	} state_e;

	state_e              state;
	state_e              state_n;
	logic [CNT_W-1:0]    cnt;
	logic [CNT_W-1:0]    cnt_n;
	logic                done_n;
	logic                valid_q;
	logic [GF_WIDTH:0]   acc;
	logic [GF_WIDTH:0]   acc_n;
	logic [GF_WIDTH+1:0] m_add;
	logic [GF_WIDTH+1:0] m_odd;
	logic [GF_WIDTH:0]   m_half;
	gf_word_t            u;
	gf_word_t            v;
	gf_word_t            r;
	gf_word_t            s;
	gf_word_t            u_n;
	gf_word_t            v_n;
	gf_word_t            r_n;
	gf_word_t            s_n;
	logic [GF_WIDTH:0]   r_step;
	logic [GF_WIDTH:0]   s_step;
	gf_word_t            value_q;
	gf_word_t            value_n;

	// x below 2m, one subtraction brings it under m
	function automatic gf_word_t fold(input logic [GF_WIDTH:0] x, input gf_word_t m);
		logic [GF_WIDTH:0] d;
		d = x - {1'b0, m};
		return (x >= {1'b0, m}) ? d[GF_WIDTH-1:0] : x[GF_WIDTH-1:0];
	endfunction

	// x/2 mod m for odd m
	function automatic gf_word_t halve(input gf_word_t x, input gf_word_t m);
		logic [GF_WIDTH:0] t;
		t = x[0] ? {1'b0, x} + {1'b0, m} : {1'b0, x};
		return t[GF_WIDTH:1];
	endfunction

	////////////////////////////////////////////////////////////
	// montgomery step, acc = (acc + a_i*b) / 2 mod p
	////////////////////////////////////////////////////////////

	assign m_add = {1'b0, acc} + (i_operands.a[cnt[IDX_W-1:0]] ? {2'b0, i_operands.b} : '0);
	assign m_odd = m_add + {2'b0, i_operands.p};
	assign m_half = m_add[0] ? m_odd[GF_WIDTH+1:1] : m_add[GF_WIDTH+1:1];

	always_comb begin
		state_n = state;
		cnt_n = cnt;
		done_n = 1'b0;
		acc_n = acc;
		u_n = u;
		v_n = v;
		r_n = r;
		s_n = s;
		value_n = value_q;
		r_step = {1'b0, r};
		s_step = {1'b0, s};
		case (state)
			ST_IDLE: begin
				cnt_n = '0;
				if (i_go && i_operands.op == OP_MUL) begin
					acc_n = '0;
					state_n = ST_MUL;
				end else if (i_go && i_operands.op == OP_DIV) begin
					u_n = i_operands.p;
					v_n = i_operands.b;
					r_n = '0;
					s_n = i_operands.a;
					state_n = ST_DLOOP;
				end
			end
			ST_MUL: begin
				acc_n = m_half;
				cnt_n = cnt + 1'b1;
				if (cnt == CNT_W'(GF_WIDTH - 1)) begin
					state_n = ST_MFIX;
				end
			end
			ST_MFIX: begin
				value_n = fold(acc, i_operands.p);
				done_n = 1'b1;
				state_n = ST_IDLE;
			end
			ST_DLOOP: begin
				if (v == '0) begin
					// r holds -a/b * 2^k here
					r_n = (r == '0) ? '0 : i_operands.p - r;
					state_n = ST_DHALF;
				end else begin
					if (!u[0]) begin
						u_n = u >> 1;
						s_step = {s, 1'b0};
					end else if (!v[0]) begin
						v_n = v >> 1;
						r_step = {r, 1'b0};
					end else if (u > v) begin
						u_n = (u - v) >> 1;
						r_step = {1'b0, r} + {1'b0, s};
						s_step = {s, 1'b0};
					end else begin
						v_n = (v - u) >> 1;
						s_step = {1'b0, r} + {1'b0, s};
						r_step = {r, 1'b0};
					end
					r_n = fold(r_step, i_operands.p);
					s_n = fold(s_step, i_operands.p);
					cnt_n = cnt + 1'b1;
				end
			end
			ST_DHALF: begin
				// strip the 2^k picked up in the loop
				if (cnt != '0) begin
					r_n = halve(r, i_operands.p);
					cnt_n = cnt - 1'b1;
				end else begin
					value_n = r;
					done_n = 1'b1;
					state_n = ST_IDLE;
				end
			end
			default: begin
				state_n = ST_IDLE;
			end
		endcase
	end

	always_ff @(posedge i_clk or posedge i_rst) begin
		if (i_rst) begin
			state <= ST_IDLE;
			cnt <= '0;
			valid_q <= 1'b0;
		end else begin
			state <= state_n;
			cnt <= cnt_n;
			valid_q <= done_n;
		end
	end

	always_ff @(posedge i_clk) begin
		acc <= acc_n;
		u <= u_n;
		v <= v_n;
		r <= r_n;
		s <= s_n;
		value_q <= value_n;
	end

	assign o_result = '{value: value_q, valid: valid_q};

endmodule

// ==== design/gf_result_unload.sv ====
`timescale 1ns/10ps

module gf_result_unload (
	input  logic                         i_clk,
	input  logic                         i_rst,
	input  gf_pkg::gf_result_t           i_add_sub,
	input  gf_pkg::gf_result_t           i_mul_div,
	output logic [gf_pkg::NIB_WIDTH-1:0] o_nib,
	output logic                         o_nib_valid,
	output logic                         o_done
);
	import gf_pkg::*;

	localparam int CNT_W = $clog2(NIB_BEATS);

	gf_word_t         shreg;
	logic [CNT_W-1:0] beat;
	logic             active;
	logic             last;
	logic             load;

	// only one unit finishes per operation
	assign load = i_add_sub.valid || i_mul_div.valid;
	assign last = active && (beat == CNT_W'(NIB_BEATS - 1));

	always_ff @(posedge i_clk or posedge i_rst) begin
		if (i_rst) begin
			active <= 1'b0;
			beat <= '0;
		end else if (load) begin
			active <= 1'b1;
			beat <= '0;
		end else if (active) begin
			beat <= beat + 1'b1;
			if (last) begin
				active <= 1'b0;
			end
		end
	end

	// low nibble first
	always_ff @(posedge i_clk) begin
		if (i_add_sub.valid) begin
			shreg <= i_add_sub.value;
		end else if (i_mul_div.valid) begin
			shreg <= i_mul_div.value;
		end else if (active) begin
			shreg <= shreg >> NIB_WIDTH;
		end
	end

	assign o_nib = active ? shreg[NIB_WIDTH-1:0] : '0;
	assign o_nib_valid = active;
	assign o_done = last;

endmodule

// ==== design/gf_nibble_top.sv ====
`timescale 1ns/10ps

module gf_nibble_top (
	input  logic                         i_clk,
	input  logic                         i_rst,
	input  logic                         i_start,
	input  logic [gf_pkg::NIB_WIDTH-1:0] i_nib_a,
	input  logic [gf_pkg::NIB_WIDTH-1:0] i_nib_b,
	input  logic [gf_pkg::NIB_WIDTH-1:0] i_nib_p,
	input  gf_pkg::gf_op_e               i_op,
	output logic [gf_pkg::NIB_WIDTH-1:0] o_nib,
	output logic                         o_nib_valid,
	output logic                         o_busy
);
	import gf_pkg::*;

	gf_operands_t operands;
	logic         go;
	logic         done;
	gf_result_t   add_sub_res;
	gf_result_t   mul_div_res;

	gf_operand_loader u_loader (
		.i_clk      (i_clk),
		.i_rst      (i_rst),
		.i_start    (i_start),
		.i_nib_a    (i_nib_a),
		.i_nib_b    (i_nib_b),
		.i_nib_p    (i_nib_p),
		.i_op       (i_op),
		.i_done     (done),
		.o_operands (operands),
		.o_go       (go),
		.o_busy     (o_busy)
	);

	// both units see every go and pick their own opcodes
	gf_add_sub_unit u_add_sub (
		.i_clk      (i_clk),
		.i_rst      (i_rst),
		.i_go       (go),
		.i_operands (operands),
		.o_result   (add_sub_res)
	);

	gf_mul_div_unit u_mul_div (
		.i_clk      (i_clk),
		.i_rst      (i_rst),
		.i_go       (go),
		.i_operands (operands),
		.o_result   (mul_div_res)
	);

	gf_result_unload u_unload (
		.i_clk       (i_clk),
		.i_rst       (i_rst),
		.i_add_sub   (add_sub_res),
		.i_mul_div   (mul_div_res),
		.o_nib       (o_nib),
		.o_nib_valid (o_nib_valid),
		.o_done      (done)
	);

endmodule

// ==== tests/tb_gf_nibble_top.sv ====
`timescale 1ns/10ps

module tb_gf_nibble_top;
	import gf_pkg::*;

	localparam int CYCLES_PER_VEC = 16 + 4 * GF_WIDTH + 8;

	logic                 i_clk;
	logic                 i_rst;
	logic                 i_start;
	logic [NIB_WIDTH-1:0] i_nib_a;
	logic [NIB_WIDTH-1:0] i_nib_b;
	logic [NIB_WIDTH-1:0] i_nib_p;
	gf_op_e               i_op;
	logic [NIB_WIDTH-1:0] o_nib;
	logic                 o_nib_valid;
	logic                 o_busy;

	logic [31:0] vec_op[$];
	logic [31:0] vec_a[$];
	logic [31:0] vec_b[$];
	logic [31:0] vec_p[$];
	logic [31:0] vec_exp[$];
	int          vec_total = 0;
	int          cur_vec = -1;
	int          err_count = 0;
	int          n_pass = 0;
	int          n_fail = 0;
	bit          file_ok;
	logic [31:0] lfsr_state = 32'd86727;

	gf_nibble_top u_dut (
		.i_clk       (i_clk),
		.i_rst       (i_rst),
		.i_start     (i_start),
		.i_nib_a     (i_nib_a),
		.i_nib_b     (i_nib_b),
		.i_nib_p     (i_nib_p),
		.i_op        (i_op),
		.o_nib       (o_nib),
		.o_nib_valid (o_nib_valid),
		.o_busy      (o_busy)
	);

	always #20 i_clk = ~i_clk;

	////////////////////////////////////////////////////////////
	// helpers
	////////////////////////////////////////////////////////////

	// taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0];
		return {s[30:0], fb};
	endfunction

	task automatic draw_gap(output int gap);
		gap = 0;
		for (int k = 0; k < 3; k++) begin
			lfsr_state = lfsr_step(lfsr_state);
			gap = (gap << 1) | int'(lfsr_state[0]);
		end
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		if (got !== expected) begin
			$display("Mismatch at time %0d ns: %s got %h expected %h", $time, name, got,
				expected);
			err_count++;
		end
	endtask

	task automatic load_vectors(output bit ok);
		int          fd;
		int          n;
		string       line;
		logic [31:0] op;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] p;
		logic [31:0] e;
		ok = 1'b0;
		fd = $fopen("tests/gf_nibble_input.txt", "r");
		if (fd != 0) begin
			ok = 1'b1;
			while (!$feof(fd)) begin
				n = $fgets(line, fd);
				// lines starting with # describe the columns
				if (n > 0 && line[0] != 8'h23) begin
					n = $sscanf(line, "%h %h %h %h %h", op, a, b, p, e);
					if (n == 5) begin
						vec_op.push_back(op);
						vec_a.push_back(a);
						vec_b.push_back(b);
						vec_p.push_back(p);
						vec_exp.push_back(e);
					end
				end
			end
			$fclose(fd);
		end
		vec_total = vec_op.size();
	endtask

	////////////////////////////////////////////////////////////
	// one operation from start to the last nibble
	////////////////////////////////////////////////////////////

	task automatic run_vector(input int idx);
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] p;
		logic [31:0] got;
		logic [63:0] lhs;
		logic [63:0] rhs;
		gf_op_e      opc;
		int          gap;
		int          lat;
		int          errs_before;
		errs_before = err_count;
		a = vec_a[idx];
		b = vec_b[idx];
		p = vec_p[idx];
		opc = gf_op_e'(vec_op[idx][1:0]);
		cur_vec = idx;
		draw_gap(gap);
		repeat (gap) @(negedge i_clk);
		check_value("o_busy", 32'(o_busy), 32'd0);
		for (int k = 0; k < NIB_BEATS; k++) begin
			i_start = (k == 0);
			i_op = opc;
			i_nib_a = a[k*NIB_WIDTH +: NIB_WIDTH];
			i_nib_b = b[k*NIB_WIDTH +: NIB_WIDTH];
			i_nib_p = p[k*NIB_WIDTH +: NIB_WIDTH];
			@(negedge i_clk);
		end
		// this start lands while the operation is running
		check_value("o_busy", 32'(o_busy), 32'd1);
		i_start = 1'b1;
		i_nib_a = '1;
		i_nib_b = '1;
		i_nib_p = '1;
		@(negedge i_clk);
		i_start = 1'b0;
		lat = NIB_BEATS + 1;
		while (!o_nib_valid) begin
			@(negedge i_clk);
			lat++;
		end
		got = '0;
		for (int k = 0; k < NIB_BEATS; k++) begin
			check_value("o_nib_valid", 32'(o_nib_valid), 32'd1);
			got[k*NIB_WIDTH +: NIB_WIDTH] = o_nib;
			@(negedge i_clk);
		end
		check_value("o_busy", 32'(o_busy), 32'd0);
		repeat (8) begin
			check_value("o_nib_valid", 32'(o_nib_valid), 32'd0);
			@(negedge i_clk);
		end
		check_value("result", got, vec_exp[idx]);
		if (opc == OP_ADD || opc == OP_SUB) begin
			check_value("first nibble latency", 32'(lat), 32'd10);
		end else if (opc == OP_MUL) begin
			// result * 2^32 must match a * b in the field
			lhs = {got, 32'h0} % {32'h0, p};
			rhs = ({32'h0, a} * {32'h0, b}) % {32'h0, p};
			check_value("result times 2^32 mod p", lhs[31:0], rhs[31:0]);
		end else begin
			lhs = ({32'h0, got} * {32'h0, b}) % {32'h0, p};
			check_value("result times b mod p", lhs[31:0], a);
		end
		if (err_count == errs_before) begin
			n_pass++;
			$display("test %0d %s ok", idx, opc.name());
		end else begin
			n_fail++;
			$display("test %0d %s FAILED", idx, opc.name());
		end
	endtask

	////////////////////////////////////////////////////////////
	// main sequence and watchdog
	////////////////////////////////////////////////////////////

	initial begin
		i_clk = 1'b0;
		i_rst = 1'b1;
		i_start = 1'b0;
		i_nib_a = '0;
		i_nib_b = '0;
		i_nib_p = '0;
		i_op = OP_ADD;
		load_vectors(file_ok);
		if (!file_ok || vec_total == 0) begin
			$display("no test vectors could be read from tests/gf_nibble_input.txt");
			$display("Errors found");
		end else begin
			repeat (10) @(posedge i_clk);
			@(negedge i_clk);
			check_value("o_busy", 32'(o_busy), 32'd0);
			check_value("o_nib_valid", 32'(o_nib_valid), 32'd0);
			i_rst = 1'b0;
			@(negedge i_clk);
			check_value("o_busy", 32'(o_busy), 32'd0);
			check_value("o_nib_valid", 32'(o_nib_valid), 32'd0);
			check_value("o_nib", 32'(o_nib), 32'd0);
			for (int i = 0; i < vec_total; i++) begin
				run_vector(i);
			end
			$display("tests passed %0d failed %0d, check errors %0d", n_pass, n_fail,
				err_count);
			if (n_fail == 0 && err_count == 0) begin
				$display("No errors");
			end else begin
				$display("Errors found");
			end
		end
		$finish;
	end

	initial begin
		wait (vec_total > 0);
		repeat (vec_total * CYCLES_PER_VEC + 50) @(posedge i_clk);
		$display("timeout, vector %0d never produced its output", cur_vec);
		$display("Errors found");
		$finish;
	end

endmodule

// ==== tests/gf_nibble_input.txt ====
# columns: op a b p expected, all hex
# op 0 add, 1 sub, 2 montgomery mul (a*b*2^-32 mod p), 3 div (a/b mod p)
0 00000005 00000007 0000000d 0000000c
0 00000009 00000004 0000000d 00000000
0 0000000c 0000000c 0000000d 0000000b
0 fffffffa fffffff0 fffffffb ffffffef
0 40000000 3fffffff 7fffffff 00000000
1 00000004 00000009 0000000d 00000008
1 00000007 00000007 0000000d 00000000
1 00000001 fffffffa fffffffb 00000002
1 12345678 02345678 7fffffff 10000000
2 00000005 00000007 0000000d 00000001
2 00001234 00005678 00010001 0000fa3b
2 00000006 0000000a 7fffffff 0000001e
2 00000003 00000005 7fffffff 40000007
2 7ffffffe 7ffffffe 7fffffff 40000000
3 00000007 00000005 0000000d 00000004
3 00000001 00000002 7fffffff 40000000
3 00000001 00000003 00010001 00005556
3 00000001 00000003 7fffffff 55555555

// ==== gf_nibble.f ====
design/gf_pkg.sv
design/gf_operand_loader.sv
design/gf_add_sub_unit.sv
design/gf_mul_div_unit.sv
design/gf_result_unload.sv
design/gf_nibble_top.sv
tests/tb_gf_nibble_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the GF nibble testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary -j 0 -f gf_nibble.f --top-module tb_gf_nibble_top -o sim_tb \
	|| { echo "verilator build failed"; exit 1; }

./obj_dir/sim_tb > sim.log 2>&1 ; cat sim.log

grep -qx "No errors" sim.log && { echo "simulation passed"; exit 0; } \
	|| { echo "simulation failed"; exit 1; }
